// File: src/istream_defs.svh
// ------------------------------
// instruction stream sizing macros
// ------------------------------
`ifndef ISTREAM_DEFS_SVH
`define ISTREAM_DEFS_SVH

// 16-bit parcels per fetch block
`define ISTREAM_PARCELS 4

// queue depth in blocks, power of two
`define ISTREAM_SETS 8
`define ISTREAM_INDEX_WIDTH 3

// instructions handed out per cycle
`define ISTREAM_WAYS 4

`endif

// File: src/istream_pkg.sv
// ------------------------------
// instruction word union and parcel length test
// ------------------------------
package istream_pkg;

    // one 32-bit instruction word, seen whole or as two parcels
    typedef union packed {
        logic [31:0] word;
        // parcel[0] is the low half, the first parcel in memory order
        logic [1:0][15:0] parcel;
    } instr_word_u;

    // ------------------------------
    // length predecode
    // ------------------------------

    // a 32-bit instruction has both low bits set
    function automatic logic parcel_is_compressed(input logic [15:0] parcel);
        return parcel[1:0] != 2'b11;
    endfunction

endpackage

// File: src/istream_if.sv
// ------------------------------
// predecoded block and head window interfaces
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

// one predecoded block, predecoder to queue
interface fetch_block_if;
    logic                                  valid;
    logic [`ISTREAM_PARCELS-1:0][15:0]     parcels;
    logic [`ISTREAM_PARCELS-1:0]           parcel_valid;
    logic [`ISTREAM_PARCELS-1:0]           compressed;
    logic [31:0]                           pc;
    logic                                  full;

    modport src (output valid, parcels, parcel_valid, compressed, pc, input full);
    modport dst (input valid, parcels, parcel_valid, compressed, pc, output full);
endinterface

// two oldest queue sets, queue to aligner
interface istream_window_if;
    logic                                  set0_valid;
    logic                                  set1_valid;
    logic [`ISTREAM_PARCELS-1:0][15:0]     set0_parcels;
    logic [`ISTREAM_PARCELS-1:0][15:0]     set1_parcels;
    logic [`ISTREAM_PARCELS-1:0]           set0_parcel_valid;
    logic [`ISTREAM_PARCELS-1:0]           set1_parcel_valid;
    logic [`ISTREAM_PARCELS-1:0]           set0_compressed;
    logic [`ISTREAM_PARCELS-1:0]           set1_compressed;
    logic [31:0]                           set0_pc;
    logic [31:0]                           set1_pc;
    // sets to retire at the next edge, 0 to 2
    logic [1:0]                            advance;

    modport head (
        output set0_valid, set1_valid, set0_parcels, set1_parcels,
        output set0_parcel_valid, set1_parcel_valid, set0_compressed, set1_compressed,
        output set0_pc, set1_pc,
        input advance
    );
    modport take (
        input set0_valid, set1_valid, set0_parcels, set1_parcels,
        input set0_parcel_valid, set1_parcel_valid, set0_compressed, set1_compressed,
        input set0_pc, set1_pc,
        output advance
    );
endinterface

// File: src/fetch_predecode.sv
// ------------------------------
// fetch block register with compressed parcel marking
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

module fetch_predecode (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  flush,
    input  logic                                  valid_SENQ,
    input  logic [`ISTREAM_PARCELS-1:0]           parcel_valid_SENQ,
    input  logic [`ISTREAM_PARCELS-1:0][15:0]     parcels_SENQ,
    input  logic [31:0]                           PC_SENQ,
    output logic                                  stall_SENQ,
    fetch_block_if.src                            blk
);
    import istream_pkg::*;

    logic                                  load_en;
    logic [`ISTREAM_PARCELS-1:0]           compressed_in;

    // length marks computed as the block enters
    always_comb begin
        for (int i = 0; i < `ISTREAM_PARCELS; i++) begin
            compressed_in[i] = parcel_is_compressed(parcels_SENQ[i]);
        end
    end

    // register frees up when empty or when the queue takes it
    assign load_en    = ~blk.valid | ~blk.full;
    assign stall_SENQ = blk.valid & blk.full;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            blk.valid <= 1'b0;
        end else if (flush) begin
            blk.valid <= 1'b0;
        end else if (load_en) begin
            blk.valid <= valid_SENQ;
        end
    end

    always_ff @(posedge CLK) begin
        if (load_en & valid_SENQ) begin
            blk.parcels      <= parcels_SENQ;
            blk.parcel_valid <= parcel_valid_SENQ;
            blk.compressed   <= compressed_in;
            blk.pc           <= PC_SENQ;
        end
    end

endmodule

// File: src/istream_queue.sv
// ------------------------------
// circular block queue with two-set head window
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

module istream_queue (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    fetch_block_if.dst           blk,
    istream_window_if.head       win
);
    localparam int IW = `ISTREAM_INDEX_WIDTH;

    // ------------------------------
    // storage and pointers
    // ------------------------------

    logic [`ISTREAM_SETS-1:0]                                 entry_valid;
    logic [`ISTREAM_SETS-1:0][`ISTREAM_PARCELS-1:0][15:0]     entry_parcels;
    logic [`ISTREAM_SETS-1:0][`ISTREAM_PARCELS-1:0]           entry_parcel_valid;
    logic [`ISTREAM_SETS-1:0][`ISTREAM_PARCELS-1:0]           entry_compressed;
    logic [`ISTREAM_SETS-1:0][31:0]                           entry_pc;

    // msb is the wrap bit
    logic [IW:0] enq_ptr;
    logic [IW:0] deq_ptr0;
    logic [IW:0] deq_ptr1;
    logic        enq_fire;

    // same slot, opposite lap
    assign blk.full = (enq_ptr[IW-1:0] == deq_ptr0[IW-1:0]) & (enq_ptr[IW] != deq_ptr0[IW]);
    assign enq_fire = blk.valid & ~blk.full;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            entry_valid <= '0;
            enq_ptr     <= '0;
            deq_ptr0    <= '0;
            deq_ptr1    <= (IW+1)'(1);
        end else if (flush) begin
            entry_valid <= '0;
            enq_ptr     <= '0;
            deq_ptr0    <= '0;
            deq_ptr1    <= (IW+1)'(1);
        end else begin
            // retire first, a write to a freed slot still lands
            if (win.advance != 2'd0) begin
                entry_valid[deq_ptr0[IW-1:0]] <= 1'b0;
            end
            if (win.advance == 2'd2) begin
                entry_valid[deq_ptr1[IW-1:0]] <= 1'b0;
            end
            if (enq_fire) begin
                entry_valid[enq_ptr[IW-1:0]] <= 1'b1;
                enq_ptr <= enq_ptr + 1'b1;
            end
            deq_ptr0 <= deq_ptr0 + (IW+1)'(win.advance);
            deq_ptr1 <= deq_ptr1 + (IW+1)'(win.advance);
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            entry_parcels[enq_ptr[IW-1:0]]      <= blk.parcels;
            entry_parcel_valid[enq_ptr[IW-1:0]] <= blk.parcel_valid;
            entry_compressed[enq_ptr[IW-1:0]]   <= blk.compressed;
            entry_pc[enq_ptr[IW-1:0]]           <= blk.pc;
        end
    end

    // ------------------------------
    // head window
    // ------------------------------

    assign win.set0_valid        = entry_valid[deq_ptr0[IW-1:0]];
    assign win.set1_valid        = entry_valid[deq_ptr1[IW-1:0]];
    assign win.set0_parcels      = entry_parcels[deq_ptr0[IW-1:0]];
    assign win.set1_parcels      = entry_parcels[deq_ptr1[IW-1:0]];
    assign win.set0_parcel_valid = entry_parcel_valid[deq_ptr0[IW-1:0]];
    assign win.set1_parcel_valid = entry_parcel_valid[deq_ptr1[IW-1:0]];
    assign win.set0_compressed   = entry_compressed[deq_ptr0[IW-1:0]];
    assign win.set1_compressed   = entry_compressed[deq_ptr1[IW-1:0]];
    assign win.set0_pc           = entry_pc[deq_ptr0[IW-1:0]];
    assign win.set1_pc           = entry_pc[deq_ptr1[IW-1:0]];

endmodule

// File: src/way_align.sv
// ------------------------------
// parcel walk and output way registers
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

module way_align (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              flush,
    input  logic                              stall_SDEQ,
    istream_window_if.take                    win,
    output logic [`ISTREAM_WAYS-1:0]          valid_by_way_SDEQ,
    output logic [`ISTREAM_WAYS-1:0]          compressed_by_way_SDEQ,
    output logic [`ISTREAM_WAYS-1:0][31:0]    instr_4B_by_way_SDEQ,
    output logic [`ISTREAM_WAYS-1:0][31:0]    PC_by_way_SDEQ
);
    import istream_pkg::*;

    localparam int WIN    = 2 * `ISTREAM_PARCELS;
    localparam int WIN_W  = $clog2(WIN);
    localparam int OFS_W  = $clog2(`ISTREAM_PARCELS);
    localparam int WAY_W  = $clog2(`ISTREAM_WAYS);

    // set0 parcels in the low half
    logic [WIN-1:0][15:0]                  win_parcels;
    logic [WIN-1:0]                        win_pv;
    logic [WIN-1:0]                        win_comp;
    logic [1:0]                            set_valid;
    logic [1:0][31:0]                      set_pc;

    logic [OFS_W-1:0]                      offset;
    // first window position not yet consumed
    logic [WIN_W:0]                        cons;
    logic [1:0]                            scan_adv;
    logic [`ISTREAM_WAYS-1:0]              nxt_valid;
    logic [`ISTREAM_WAYS-1:0]              nxt_comp;
    logic [`ISTREAM_WAYS-1:0][31:0]        nxt_instr;
    logic [`ISTREAM_WAYS-1:0][31:0]        nxt_pc;

    assign win_parcels = {win.set1_parcels, win.set0_parcels};
    assign win_pv      = {win.set1_parcel_valid, win.set0_parcel_valid};
    assign win_comp    = {win.set1_compressed, win.set0_compressed};
    assign set_valid   = {win.set1_valid, win.set0_valid};
    assign set_pc      = {win.set1_pc, win.set0_pc};

    // ------------------------------
    // parcel walk
    // ------------------------------

    always_comb begin
        logic [WAY_W:0]   n;
        logic             pend;
        logic             done;
        logic             emit;
        logic             is_c;
        logic [WIN_W-1:0] low_p;
        logic [WIN_W-1:0] first;
        instr_word_u      w;

        n         = '0;
        pend      = 1'b0;
        done      = 1'b0;
        emit      = 1'b0;
        is_c      = 1'b0;
        low_p     = '0;
        first     = '0;
        w         = '0;
        cons      = (WIN_W+1)'(offset);
        nxt_valid = '0;
        nxt_comp  = '0;
        nxt_instr = '0;
        nxt_pc    = '0;

        for (int p = 0; p < WIN; p++) begin
            if (!done && p >= int'(offset)) begin
                emit = 1'b0;
                if (!set_valid[p / `ISTREAM_PARCELS]) begin
                    // block not queued yet, wait for it
                    done = 1'b1;
                end else if (!win_pv[p]) begin
                    // hole, only counts as consumed between instructions
                    if (!pend) begin
                        cons = (WIN_W+1)'(p + 1);
                    end
                end else if (pend) begin
                    w.parcel[0] = win_parcels[low_p];
                    w.parcel[1] = win_parcels[p];
                    first       = low_p;
                    is_c        = 1'b0;
                    emit        = 1'b1;
                    pend        = 1'b0;
                end else if (win_comp[p]) begin
                    w.parcel[0] = win_parcels[p];
                    w.parcel[1] = 16'h0000;
                    first       = WIN_W'(p);
                    is_c        = 1'b1;
                    emit        = 1'b1;
                end else begin
                    // low half of a 32-bit instruction
                    pend  = 1'b1;
                    low_p = WIN_W'(p);
                end

                if (emit) begin
                    nxt_valid[n[WAY_W-1:0]] = 1'b1;
                    nxt_comp[n[WAY_W-1:0]]  = is_c;
                    nxt_instr[n[WAY_W-1:0]] = w.word;
                    nxt_pc[n[WAY_W-1:0]]    = set_pc[first[WIN_W-1]]
                                              + 32'({first[WIN_W-2:0], 1'b0});
                    cons = (WIN_W+1)'(p + 1);
                    n    = n + 1'b1;
                    if (n == (WAY_W+1)'(`ISTREAM_WAYS)) begin
                        done = 1'b1;
                    end
                end
            end
        end
    end

    // whole sets behind the consumed point
    assign scan_adv    = 2'(cons / `ISTREAM_PARCELS);
    assign win.advance = stall_SDEQ ? 2'd0 : scan_adv;

    // ------------------------------
    // output ways
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_by_way_SDEQ <= '0;
            offset            <= '0;
        end else if (flush) begin
            valid_by_way_SDEQ <= '0;
            offset            <= '0;
        end else if (~stall_SDEQ) begin
            valid_by_way_SDEQ <= nxt_valid;
            offset            <= cons[OFS_W-1:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_SDEQ) begin
            compressed_by_way_SDEQ <= nxt_comp;
            instr_4B_by_way_SDEQ   <= nxt_instr;
            PC_by_way_SDEQ         <= nxt_pc;
        end
    end

endmodule

// File: src/istream_top.sv
// ------------------------------
// instruction stream top level
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

module istream_top (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  flush,

    // enqueue side
    input  logic                                  valid_SENQ,
    input  logic [`ISTREAM_PARCELS-1:0]           parcel_valid_SENQ,
    input  logic [`ISTREAM_PARCELS-1:0][15:0]     parcels_SENQ,
    input  logic [31:0]                           PC_SENQ,
    output logic                                  stall_SENQ,

    // dequeue side
    input  logic                                  stall_SDEQ,
    output logic [`ISTREAM_WAYS-1:0]              valid_by_way_SDEQ,
    output logic [`ISTREAM_WAYS-1:0]              compressed_by_way_SDEQ,
    output logic [`ISTREAM_WAYS-1:0][31:0]        instr_4B_by_way_SDEQ,
    output logic [`ISTREAM_WAYS-1:0][31:0]        PC_by_way_SDEQ
);

    fetch_block_if    blk_if ();
    istream_window_if win_if ();

    fetch_predecode predecode0 (
        .CLK               (CLK),
        .nRST              (nRST),
        .flush             (flush),
        .valid_SENQ        (valid_SENQ),
        .parcel_valid_SENQ (parcel_valid_SENQ),
        .parcels_SENQ      (parcels_SENQ),
        .PC_SENQ           (PC_SENQ),
        .stall_SENQ        (stall_SENQ),
        .blk               (blk_if)
    );

    istream_queue queue0 (
        .CLK   (CLK),
        .nRST  (nRST),
        .flush (flush),
        .blk   (blk_if),
        .win   (win_if)
    );

    way_align align0 (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .flush                  (flush),
        .stall_SDEQ             (stall_SDEQ),
        .win                    (win_if),
        .valid_by_way_SDEQ      (valid_by_way_SDEQ),
        .compressed_by_way_SDEQ (compressed_by_way_SDEQ),
        .instr_4B_by_way_SDEQ   (instr_4B_by_way_SDEQ),
        .PC_by_way_SDEQ         (PC_by_way_SDEQ)
    );

endmodule

// File: tb/istream_checker.sv
// ------------------------------
// parcel stream model and output way comparison
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

module istream_checker (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  flush,
    input  logic                                  valid_SENQ,
    input  logic [`ISTREAM_PARCELS-1:0]           parcel_valid_SENQ,
    input  logic [`ISTREAM_PARCELS-1:0][15:0]     parcels_SENQ,
    input  logic [31:0]                           PC_SENQ,
    input  logic                                  stall_SENQ,
    input  logic                                  stall_SDEQ,
    input  logic [`ISTREAM_WAYS-1:0]              valid_by_way_SDEQ,
    input  logic [`ISTREAM_WAYS-1:0]              compressed_by_way_SDEQ,
    input  logic [`ISTREAM_WAYS-1:0][31:0]        instr_4B_by_way_SDEQ,
    input  logic [`ISTREAM_WAYS-1:0][31:0]        PC_by_way_SDEQ,
    input  int                                    test_num,
    output int                                    pending,
    output int                                    checks,
    output int                                    errors
);
    import istream_pkg::*;

    // accepted parcels not yet seen on the outputs
    logic [15:0]                       parcel_q [$];
    logic [31:0]                       pc_q [$];

    logic                              held;
    logic [`ISTREAM_WAYS-1:0]          held_valid;
    logic [`ISTREAM_WAYS-1:0]          held_comp;
    logic [`ISTREAM_WAYS-1:0][31:0]    held_instr;
    logic [`ISTREAM_WAYS-1:0][31:0]    held_pc;
    logic                              input_stall_seen;
    int                                last_test;
    int                                test_checks;
    int                                test_errors;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        test_errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    // pop one instruction from the model and compare it with way w
    task automatic take_expected(input int w);
        logic [15:0] lo;
        logic [15:0] hi;
        logic [31:0] exp_pc;

        if (parcel_q.size() == 0) begin
            note_failure($sformatf("way %0d is valid but no parcel is pending", w));
        end else begin
            lo     = parcel_q.pop_front();
            exp_pc = pc_q.pop_front();
            if (parcel_is_compressed(lo)) begin
                check_value($sformatf("instr_4B_by_way_SDEQ[%0d]", w),
                            instr_4B_by_way_SDEQ[w], {16'h0000, lo});
                check_value($sformatf("compressed_by_way_SDEQ[%0d]", w),
                            32'(compressed_by_way_SDEQ[w]), 32'd1);
            end else if (parcel_q.size() == 0) begin
                note_failure($sformatf("way %0d shows a 32-bit instruction with no high parcel", w));
            end else begin
                hi = parcel_q.pop_front();
                void'(pc_q.pop_front());
                check_value($sformatf("instr_4B_by_way_SDEQ[%0d]", w),
                            instr_4B_by_way_SDEQ[w], {hi, lo});
                check_value($sformatf("compressed_by_way_SDEQ[%0d]", w),
                            32'(compressed_by_way_SDEQ[w]), 32'd0);
            end
            check_value($sformatf("PC_by_way_SDEQ[%0d]", w), PC_by_way_SDEQ[w], exp_pc);
        end
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            parcel_q.delete();
            pc_q.delete();
            held             = 1'b0;
            input_stall_seen = 1'b0;
            last_test        = 0;
            test_checks      = 0;
            test_errors      = 0;
            checks           = 0;
            errors           = 0;
        end else begin
            if (test_num != last_test) begin
                if (last_test != 0) begin
                    $display("test %0d finished: %0d checks, %0d errors",
                             last_test, test_checks, test_errors);
                end
                // test number 0 marks the end of the run
                if (test_num == 0 && !input_stall_seen) begin
                    note_failure("stall_SENQ was never raised although the queue was filled");
                end
                last_test   = test_num;
                test_checks = 0;
                test_errors = 0;
            end

            // ------------------------------
            // outputs frozen by the last stall
            // ------------------------------
            if (held) begin
                check_value("valid_by_way_SDEQ", 32'(valid_by_way_SDEQ), 32'(held_valid));
                check_value("compressed_by_way_SDEQ", 32'(compressed_by_way_SDEQ),
                            32'(held_comp));
                for (int w = 0; w < `ISTREAM_WAYS; w++) begin
                    check_value($sformatf("instr_4B_by_way_SDEQ[%0d]", w),
                                instr_4B_by_way_SDEQ[w], held_instr[w]);
                    check_value($sformatf("PC_by_way_SDEQ[%0d]", w),
                                PC_by_way_SDEQ[w], held_pc[w]);
                end
            end

            // nothing pending means nothing may be shown
            if (parcel_q.size() == 0) begin
                check_value("valid_by_way_SDEQ", 32'(valid_by_way_SDEQ), 32'd0);
                // an empty stream cannot fill the queue
                check_value("stall_SENQ", 32'(stall_SENQ), 32'd0);
            end else if (!stall_SDEQ) begin
                for (int w = 0; w < `ISTREAM_WAYS; w++) begin
                    if (valid_by_way_SDEQ[w]) begin
                        take_expected(w);
                    end
                end
            end

            // ------------------------------
            // model update
            // ------------------------------
            if (stall_SENQ) begin
                input_stall_seen = 1'b1;
            end
            if (flush) begin
                parcel_q.delete();
                pc_q.delete();
            end else if (valid_SENQ && !stall_SENQ) begin
                for (int i = 0; i < `ISTREAM_PARCELS; i++) begin
                    if (parcel_valid_SENQ[i]) begin
                        parcel_q.push_back(parcels_SENQ[i]);
                        pc_q.push_back(PC_SENQ + 32'(2 * i));
                    end
                end
            end

            held       = stall_SDEQ && !flush;
            held_valid = valid_by_way_SDEQ;
            held_comp  = compressed_by_way_SDEQ;
            held_instr = instr_4B_by_way_SDEQ;
            held_pc    = PC_by_way_SDEQ;
        end
        pending = parcel_q.size();
    end

endmodule

// File: tb/istream_tb.sv
// ------------------------------
// istream testbench top, vector driver and DUT
// ------------------------------
`timescale 1ns/1ns
`include "istream_defs.svh"

module istream_tb;

    localparam int FIELDS      = 10;
    localparam int MAX_LINES   = 64;
    localparam int HOLD_LIMIT  = 50;
    localparam int DRAIN_LIMIT = 200;

    logic                                  CLK;
    logic                                  nRST;
    logic                                  flush;
    logic                                  valid_SENQ;
    logic [`ISTREAM_PARCELS-1:0]           parcel_valid_SENQ;
    logic [`ISTREAM_PARCELS-1:0][15:0]     parcels_SENQ;
    logic [31:0]                           PC_SENQ;
    logic                                  stall_SENQ;
    logic                                  stall_SDEQ;
    logic [`ISTREAM_WAYS-1:0]              valid_by_way_SDEQ;
    logic [`ISTREAM_WAYS-1:0]              compressed_by_way_SDEQ;
    logic [`ISTREAM_WAYS-1:0][31:0]        instr_4B_by_way_SDEQ;
    logic [`ISTREAM_WAYS-1:0][31:0]        PC_by_way_SDEQ;

    // ten fields per vector line
    logic [31:0] vec [0:FIELDS*MAX_LINES-1];
    int          test_num;
    int          pending;
    int          checks;
    int          errors;

    istream_top dut0 (.*);

    istream_checker chk0 (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic apply_line(input int n);
        int b;
        b                 = n * FIELDS;
        flush             = vec[b + 1][0];
        valid_SENQ        = vec[b + 2][0];
        parcel_valid_SENQ = vec[b + 3][`ISTREAM_PARCELS-1:0];
        PC_SENQ           = vec[b + 4];
        for (int i = 0; i < `ISTREAM_PARCELS; i++) begin
            parcels_SENQ[i] = vec[b + 5 + i][15:0];
        end
        stall_SDEQ        = vec[b + 9][0];
    endtask

    // idle inputs until every accepted parcel has come out
    task automatic drain(output bit expired);
        int cycles;
        cycles  = 0;
        expired = 1'b0;
        while (!expired && (cycles < 2 || pending != 0)) begin
            @(negedge CLK);
            flush      = 1'b0;
            valid_SENQ = 1'b0;
            stall_SDEQ = 1'b0;
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("drain timed out, %0d parcels were entered but never came out",
                         pending);
                expired = 1'b1;
            end
        end
    endtask

    initial begin
        int line;
        int hold;
        bit expired;

        line              = 0;
        hold              = 0;
        expired           = 1'b0;
        test_num          = 0;
        nRST              = 1'b0;
        flush             = 1'b0;
        valid_SENQ        = 1'b0;
        parcel_valid_SENQ = '0;
        parcels_SENQ      = '0;
        PC_SENQ           = '0;
        stall_SDEQ        = 1'b0;
        $readmemh("tb/istream_vectors.txt", vec);
        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        while (!expired && line < MAX_LINES && vec[line * FIELDS] != 0) begin
            if (test_num != 0 && vec[line * FIELDS] != test_num) begin
                drain(expired);
            end
            if (!expired) begin
                @(negedge CLK);
                test_num = vec[line * FIELDS];
                apply_line(line);
                // a refused block is offered again next cycle
                if (valid_SENQ && stall_SENQ) begin
                    hold++;
                    if (hold > HOLD_LIMIT) begin
                        $display("input stall never released, vector line %0d held %0d cycles",
                                 line, hold);
                        expired = 1'b1;
                    end
                end else begin
                    hold = 0;
                    line++;
                end
            end
        end
        if (!expired) begin
            drain(expired);
        end
        test_num = 0;
        repeat (2) @(negedge CLK);

        $display("all tests finished: %0d checks, %0d errors", checks, errors);
        if (!expired && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/istream_pkg.sv
src/istream_if.sv
src/fetch_predecode.sv
src/istream_queue.sv
src/way_align.sv
src/istream_top.sv
tb/istream_checker.sv
tb/istream_tb.sv

// File: run_verilator.sh
#!/bin/sh
# build the istream testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f verilog.f --top-module istream_tb -o istream_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/istream_sim); then
    echo "$sim_out"
    echo "simulation exited with an error status"
    exit 1
fi

echo "$sim_out"
if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: tb/istream_vectors.txt
// test flush valid_SENQ parcel_valid_SENQ PC_SENQ parcel0 parcel1 parcel2 parcel3 stall_SDEQ
// all fields hex, one line per cycle, a test number of 0 ends the list
// 1: idle after reset
1 0 0 0 00000000 0000 0000 0000 0000 0
1 0 0 0 00000000 0000 0000 0000 0000 0
1 0 0 0 00000000 0000 0000 0000 0000 0
// 2: compressed only
2 0 1 f 00001000 4501 4505 4509 450d 0
2 0 1 f 00001008 4511 4515 4519 451d 0
// 3: 32-bit instructions, one spans the first two blocks
3 0 1 f 00002000 0013 00a5 4601 1103 0
3 0 1 f 00002008 2233 4605 3013 0456 0
3 0 1 f 00003000 0002 5513 abcd 0006 0
// 4: parcels with a clear valid bit
4 0 1 b 00004000 4701 4705 dead 470d 0
4 0 1 6 00004010 beef 8813 0099 beef 0
// 5: output stall fills the queue, released on the last block
5 0 1 f 00005000 5001 5005 5009 500d 0
5 0 1 f 00005008 5101 5105 5109 510d 0
5 0 1 f 00005010 5201 5205 5209 520d 0
5 0 1 f 00005018 5301 5305 5309 530d 1
5 0 1 f 00005020 5401 5405 5409 540d 1
5 0 1 f 00005028 5501 5505 5509 550d 1
5 0 1 f 00005030 5601 5605 5609 560d 1
5 0 1 f 00005038 5701 5705 5709 570d 1
5 0 1 f 00005040 5801 5805 5809 580d 1
5 0 1 f 00005048 5901 5905 5909 590d 1
5 0 1 f 00005050 5a01 5a05 5a09 5a0d 0
// 6: flush in the middle of a stream
6 0 1 f 00006000 6001 6005 6009 600d 0
6 0 1 f 00006008 6011 6015 6019 601d 0
6 0 1 f 00006010 6021 6025 6029 602d 0
6 1 0 0 00000000 0000 0000 0000 0000 0
6 0 1 f 00006100 0013 1234 6031 6035 0
0 0 0 0 00000000 0000 0000 0000 0000 0
